//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_scaler_ctrl
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) $(SEED_ARGS) 2>&1 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- aspect_window_calc.sv
`default_nettype none
`timescale 1ns/10ps

module aspect_window_calc (
	input  wire logic                      clk_sys,
	input  wire logic                      resetd,
	scaler_cfg_if.cfg_dst                  i_cfg,
	input  wire logic [sys_pkg::DIM_W-1:0] i_arx,
	input  wire logic [sys_pkg::DIM_W-1:0] i_ary,
	output logic [sys_pkg::DIM_W-1:0]      o_hmin,
	output logic [sys_pkg::DIM_W-1:0]      o_hmax,
	output logic [sys_pkg::DIM_W-1:0]      o_vmin,
	output logic [sys_pkg::DIM_W-1:0]      o_vmax
);
	import sys_pkg::*;

	localparam int ST_W   = $clog2(CALC_STATES);
	localparam int PROD_W = 2 * DIM_W;

	typedef enum logic [ST_W-1:0] {
		ST_SCALE,
		ST_DIV_1,
		ST_DIV_2,
		ST_DIV_3,
		ST_DIV_4,
		ST_DIV_5,
		ST_CLAMP,
		ST_UPDATE
	} calc_state_e;

	calc_state_e       state;
	logic [DIM_W-1:0]  eff_w, eff_h;
	logic [DIM_W-1:0]  arx, ary;
	logic [PROD_W-1:0] num_w, num_h;
	logic [DIM_W-1:0]  den_w, den_h;
	logic [PROD_W-1:0] quo_w, quo_h;
	logic [DIM_W-1:0]  video_w, video_h;
	logic [DIM_W-1:0]  h_off, v_off;

	////////////////////////////////////////
	// Effective size and aspect
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		eff_h <= (i_cfg.vset != '0 && i_cfg.vset < i_cfg.height) ? i_cfg.vset : i_cfg.height;
		eff_w <= (i_cfg.hset != '0 && i_cfg.hset < i_cfg.width) ? i_cfg.hset : i_cfg.width;

		// ary of zero selects an arcade preset by arx
		if (i_ary == '0) begin
			if (i_arx == DIM_W'(1)) begin
				arx <= i_cfg.arc1x;
				ary <= i_cfg.arc1y;
			end else if (i_arx == DIM_W'(2)) begin
				arx <= i_cfg.arc2x;
				ary <= i_cfg.arc2y;
			end else begin
				arx <= '0;
				ary <= '0;
			end
		end else begin
			arx <= i_arx;
			ary <= i_ary;
		end
	end

	////////////////////////////////////////
	// Scale, divide and clamp
	////////////////////////////////////////

	// Operands are held from ST_SCALE, the quotient is taken in ST_CLAMP
	assign quo_w = num_w / PROD_W'(den_w);
	assign quo_h = num_h / PROD_W'(den_h);

	always_ff @(posedge clk_sys) begin
		case (state)
			ST_SCALE: begin
				if (i_cfg.freescale || arx == '0 || ary == '0) begin
					num_w <= PROD_W'(eff_w);
					num_h <= PROD_W'(eff_h);
					den_w <= DIM_W'(1);
					den_h <= DIM_W'(1);
				end else begin
					num_w <= PROD_W'(eff_h) * PROD_W'(arx);
					num_h <= PROD_W'(eff_w) * PROD_W'(ary);
					den_w <= ary;
					den_h <= arx;
				end
			end
			ST_CLAMP: begin
				video_w <= (quo_w > PROD_W'(eff_w)) ? eff_w : quo_w[DIM_W-1:0];
				video_h <= (quo_h > PROD_W'(eff_h)) ? eff_h : quo_h[DIM_W-1:0];
			end
			default: ;
		endcase
	end

	// Centre inside the full output mode
	assign h_off = (i_cfg.width - video_w) >> 1;
	assign v_off = (i_cfg.height - video_h) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state  <= ST_SCALE;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			state <= calc_state_e'(state + 1'b1);
			if (state == ST_UPDATE) begin
				o_hmin <= h_off;
				o_hmax <= h_off + video_w - 1'b1;
				o_vmin <= v_off;
				o_vmax <= v_off + video_h - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- host_cmd_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module host_cmd_decoder (
	input  wire logic                     clk_sys,
	input  wire logic                     resetd,
	input  wire logic                     i_io_clk,
	input  wire logic                     i_io_uio,
	input  wire logic [sys_pkg::IO_W-1:0] i_io_din,
	output logic                          o_io_ack,
	output logic                          o_wr,
	output sys_pkg::cfg_field_e           o_field,
	output logic [sys_pkg::IO_W-1:0]      o_data
);
	import sys_pkg::*;

	localparam int IDX_W = 4;

	logic             io_clk_d;
	logic             accept;
	logic             has_cmd;
	host_cmd_e        cmd;
	logic [IDX_W-1:0] word_idx;
	cfg_field_e       fld_sel;
	logic             fld_hit;

	////////////////////////////////////////
	// Strobe detect and acknowledge echo
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_d <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			io_clk_d <= i_io_clk;
			o_io_ack <= io_clk_d;
		end
	end

	// Rising I/O clock with the user channel selected
	assign accept = i_io_clk & ~io_clk_d & i_io_uio;

	////////////////////////////////////////
	// Command and word tracking
	////////////////////////////////////////

	always_comb begin
		fld_sel = FLD_WIDTH;
		fld_hit = 1'b0;
		case (cmd)
			CMD_VIDEO_TIMING: begin
				// Porch and sync words are skipped
				if (word_idx == IDX_W'(0)) begin
					fld_hit = 1'b1;
				end else if (word_idx == IDX_W'(4)) begin
					fld_sel = FLD_HEIGHT;
					fld_hit = 1'b1;
				end
			end
			CMD_VSET: begin
				fld_sel = FLD_VSET;
				fld_hit = 1'b1;
			end
			CMD_HSET: begin
				fld_sel = FLD_HSET;
				fld_hit = 1'b1;
			end
			CMD_ARC: begin
				fld_hit = (word_idx < IDX_W'(4));
				case (word_idx[1:0])
					2'd0: fld_sel = FLD_ARC1X;
					2'd1: fld_sel = FLD_ARC1Y;
					2'd2: fld_sel = FLD_ARC2X;
					default: fld_sel = FLD_ARC2Y;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			cmd      <= CMD_NONE;
			word_idx <= '0;
			o_wr     <= 1'b0;
		end else begin
			o_wr <= 1'b0;
			if (!i_io_uio) begin
				has_cmd  <= 1'b0;
				cmd      <= CMD_NONE;
				word_idx <= '0;
			end else if (accept) begin
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd      <= host_cmd_e'(i_io_din[CMD_W-1:0]);
					word_idx <= '0;
				end else begin
					o_wr <= fld_hit;
					// Index saturates on long transfers
					if (!(&word_idx))
						word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			o_field <= fld_sel;
			o_data  <= i_io_din;
		end
	end

endmodule

`default_nettype wire

//--- scaler_cfg_if.sv
`default_nettype none
`timescale 1ns/10ps

interface scaler_cfg_if;
	import sys_pkg::*;

	// Output mode
	logic [DIM_W-1:0] width;
	logic [DIM_W-1:0] height;

	// Optional limits on the active area, zero means no limit
	logic [DIM_W-1:0] vset;
	logic [DIM_W-1:0] hset;
	logic             freescale;

	// Arcade aspect presets
	logic [DIM_W-1:0] arc1x;
	logic [DIM_W-1:0] arc1y;
	logic [DIM_W-1:0] arc2x;
	logic [DIM_W-1:0] arc2y;

	modport cfg_src (
		output width, height, vset, hset, freescale,
		output arc1x, arc1y, arc2x, arc2y
	);

	modport cfg_dst (
		input width, height, vset, hset, freescale,
		input arc1x, arc1y, arc2x, arc2y
	);

endinterface

`default_nettype wire

//--- sources.f
sys_pkg.sv
scaler_cfg_if.sv
host_cmd_decoder.sv
video_cfg_regs.sv
aspect_window_calc.sv
video_scaler_ctrl_top.sv
tb_video_scaler_ctrl_asserts.sv
tb_video_scaler_ctrl.sv

//--- sys_pkg.sv
`default_nettype none

package sys_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Pixel and line dimensions
	localparam int DIM_W = 12;
	// Host parallel port word
	localparam int IO_W  = 16;
	// Command byte in the first word
	localparam int CMD_W = 8;

	// Length of the window calculator sequence
	localparam int CALC_STATES = 8;

	////////////////////////////////////////
	// Host commands and bank fields
	////////////////////////////////////////

	typedef enum logic [CMD_W-1:0] {
		CMD_NONE         = 8'h00,
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_HSET         = 8'h37,
		CMD_ARC          = 8'h3A
	} host_cmd_e;

	// Free-scale rides on bit 15 of the HSET word
	typedef enum logic [2:0] {
		FLD_WIDTH,
		FLD_HEIGHT,
		FLD_VSET,
		FLD_HSET,
		FLD_ARC1X,
		FLD_ARC1Y,
		FLD_ARC2X,
		FLD_ARC2Y
	} cfg_field_e;

	// Output mode after reset, 1080p
	localparam logic [DIM_W-1:0] DEFAULT_WIDTH  = DIM_W'(1920);
	localparam logic [DIM_W-1:0] DEFAULT_HEIGHT = DIM_W'(1080);

endpackage

`default_nettype wire

//--- tb_video_scaler_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module tb_video_scaler_ctrl;
	import sys_pkg::*;

	localparam int N_RAND    = 16;
	localparam int NUM_TESTS = 8 + 3 * N_RAND;
	localparam int CHECK_DLY = 24;
	localparam int MAX_STALL = 10;

	logic             clk_sys;
	logic             resetd;
	logic             io_clk;
	logic             io_uio;
	logic [IO_W-1:0]  io_din;
	logic [DIM_W-1:0] arx;
	logic [DIM_W-1:0] ary;
	logic             io_ack;
	logic [DIM_W-1:0] hmin, hmax, vmin, vmax;

	// Expected register bank contents
	int m_width, m_height, m_vset, m_hset;
	bit m_free;
	int m_arc [4];

	int    exp_hmin, exp_hmax, exp_vmin, exp_vmax;
	bit    check_pending;
	string check_label;

	video_scaler_ctrl_top video_scaler_ctrl_top_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (io_clk),
		.i_io_uio (io_uio),
		.i_io_din (io_din),
		.i_arx    (arx),
		.i_ary    (ary),
		.o_io_ack (io_ack),
		.o_hmin   (hmin),
		.o_hmax   (hmax),
		.o_vmin   (vmin),
		.o_vmax   (vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	////////////////////////////////////////
	// Host port driver
	////////////////////////////////////////

	// Host waits here until the echo catches up
	task automatic wait_ack();
		int stall;
		stall = 0;
		while (io_ack !== io_clk) begin
			@(negedge clk_sys);
			stall++;
			if (stall > MAX_STALL) begin
				$display("Acknowledge did not follow the I/O clock within %0d cycles", MAX_STALL);
				stop_with_failure();
			end
		end
	endtask

	task automatic send_word(input logic [IO_W-1:0] word);
		@(negedge clk_sys);
		io_din = word;
		io_clk = 1'b1;
		wait_ack();
		@(negedge clk_sys);
		io_clk = 1'b0;
		wait_ack();
	endtask

	task automatic begin_cmd(input host_cmd_e cmd);
		@(negedge clk_sys);
		io_uio = 1'b1;
		send_word(IO_W'(cmd));
	endtask

	task automatic end_cmd();
		@(negedge clk_sys);
		io_uio = 1'b0;
		@(negedge clk_sys);
	endtask

	// Only words 0 and 4 carry width and height, the rest are porches
	task automatic write_timing(input int w, input int h);
		begin_cmd(CMD_VIDEO_TIMING);
		for (int i = 0; i < 8; i++) begin
			if (i == 0) begin
				send_word(IO_W'(w));
			end else if (i == 4) begin
				send_word(IO_W'(h));
			end else begin
				send_word(IO_W'($urandom));
			end
		end
		end_cmd();
		m_width  = w;
		m_height = h;
	endtask

	task automatic write_vset(input int v);
		begin_cmd(CMD_VSET);
		send_word(IO_W'(v));
		end_cmd();
		m_vset = v;
	endtask

	task automatic write_hset(input int h, input bit free);
		begin_cmd(CMD_HSET);
		send_word({free, 3'b000, DIM_W'(h)});
		end_cmd();
		m_hset = h;
		m_free = free;
	endtask

	task automatic write_arc(input int a1x, input int a1y, input int a2x, input int a2y);
		begin_cmd(CMD_ARC);
		send_word(IO_W'(a1x));
		send_word(IO_W'(a1y));
		send_word(IO_W'(a2x));
		send_word(IO_W'(a2y));
		end_cmd();
		m_arc[0] = a1x;
		m_arc[1] = a1y;
		m_arc[2] = a2x;
		m_arc[3] = a2y;
	endtask

	task automatic set_aspect(input int ax, input int ay);
		@(negedge clk_sys);
		arx = DIM_W'(ax);
		ary = DIM_W'(ay);
	endtask

	////////////////////////////////////////
	// Reference window and compare
	////////////////////////////////////////

	function automatic void ref_window(input int rx, input int ry,
			output int h_lo, output int h_hi, output int v_lo, output int v_hi);
		int eff_w, eff_h, ax, ay, vid_w, vid_h;
		eff_h = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		eff_w = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		ax = rx;
		ay = ry;
		if (ry == 0) begin
			ax = (rx == 1) ? m_arc[0] : (rx == 2) ? m_arc[2] : 0;
			ay = (rx == 1) ? m_arc[1] : (rx == 2) ? m_arc[3] : 0;
		end
		if (m_free || ax == 0 || ay == 0) begin
			vid_w = eff_w;
			vid_h = eff_h;
		end else begin
			vid_w = eff_h * ax / ay;
			vid_h = eff_w * ay / ax;
			if (vid_w > eff_w) vid_w = eff_w;
			if (vid_h > eff_h) vid_h = eff_h;
		end
		h_lo = (m_width - vid_w) / 2;
		h_hi = (h_lo + vid_w - 1) & 'hfff;
		v_lo = (m_height - vid_h) / 2;
		v_hi = (v_lo + vid_h - 1) & 'hfff;
	endfunction

	task automatic run_check(input string label);
		ref_window(int'(arx), int'(ary), exp_hmin, exp_hmax, exp_vmin, exp_vmax);
		check_label   = label;
		check_pending = 1'b1;
		wait (!check_pending);
	endtask

	initial begin
		forever begin
			wait (check_pending);
			repeat (CHECK_DLY) @(negedge clk_sys);
			check_value({check_label, " hmin"}, int'(hmin), exp_hmin);
			check_value({check_label, " hmax"}, int'(hmax), exp_hmax);
			check_value({check_label, " vmin"}, int'(vmin), exp_vmin);
			check_value({check_label, " vmax"}, int'(vmax), exp_vmax);
			check_pending = 1'b0;
		end
	end

	// Watchdog
	initial begin
		repeat (NUM_TESTS * 400) @(posedge clk_sys);
		$display("Watchdog timeout after %0d cycles, the run did not finish", NUM_TESTS * 400);
		stop_with_failure();
	end

	// Bound assertions on the DUT ports
	initial begin
		wait (video_scaler_ctrl_top_i.scaler_ctrl_asserts_i.fail_count != 0);
		$display("A bound assertion on the DUT ports failed");
		stop_with_failure();
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		void'($urandom(32'h15d9_99a2));
		resetd   = 1'b1;
		io_clk   = 1'b0;
		io_uio   = 1'b0;
		io_din   = '0;
		arx      = '0;
		ary      = '0;
		m_width  = 1920;
		m_height = 1080;
		m_vset   = 0;
		m_hset   = 0;
		m_free   = 1'b0;
		for (int i = 0; i < 4; i++) m_arc[i] = 0;
		repeat (2) @(negedge clk_sys);
		resetd = 1'b0;
		@(negedge clk_sys);
		check_value("ack after reset", int'(io_ack), 0);
		check_value("hmin after reset", int'(hmin), 0);
		check_value("hmax after reset", int'(hmax), 0);
		check_value("vmin after reset", int'(vmin), 0);
		check_value("vmax after reset", int'(vmax), 0);

		// Full 1080p window with no aspect
		run_check("reset window");
		check_value("reset hmax", int'(hmax), 1919);
		check_value("reset vmax", int'(vmax), 1079);

		// 4:3 pillarbox on 1080p
		set_aspect(4, 3);
		run_check("4:3 window");
		check_value("4:3 hmin", int'(hmin), 240);
		check_value("4:3 hmax", int'(hmax), 1679);

		for (int i = 0; i < N_RAND; i++) begin
			write_timing($urandom_range(256, 2047), $urandom_range(200, 1200));
			set_aspect($urandom_range(1, 9), $urandom_range(0, 9));
			run_check("video timing");
		end

		for (int i = 0; i < N_RAND; i++) begin
			set_aspect($urandom_range(1, 16), $urandom_range(1, 16));
			run_check("random aspect");
		end

		// Limits below the output size, then free-scale
		write_timing(1920, 1080);
		write_vset(720);
		write_hset(1280, 1'b0);
		set_aspect(0, 0);
		run_check("vset hset limits");
		write_hset(1280, 1'b1);
		set_aspect(4, 3);
		run_check("free-scale");
		for (int i = 0; i < N_RAND; i++) begin
			write_vset($urandom_range(100, m_height + 200));
			write_hset($urandom_range(100, m_width + 200), 1'($urandom_range(0, 1)));
			set_aspect($urandom_range(1, 16), $urandom_range(1, 16));
			run_check("random limits");
		end

		// Arcade presets
		write_vset(0);
		write_hset(0, 1'b0);
		write_arc($urandom_range(1, 16), $urandom_range(1, 16),
			$urandom_range(1, 16), $urandom_range(1, 16));
		set_aspect(1, 0);
		run_check("preset 1");
		set_aspect(2, 0);
		run_check("preset 2");
		set_aspect(3, 0);
		run_check("no preset");

		// Words with the select low are ignored
		send_word(IO_W'(CMD_VSET));
		send_word(IO_W'(100));
		run_check("select low");

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_video_scaler_ctrl_asserts.sv
`default_nettype none
`timescale 1ns/10ps

module scaler_ctrl_asserts (
	input wire logic                      clk_sys,
	input wire logic                      resetd,
	input wire logic                      i_io_clk,
	input wire logic                      o_io_ack,
	input wire logic [sys_pkg::DIM_W-1:0] o_hmin,
	input wire logic [sys_pkg::DIM_W-1:0] o_hmax,
	input wire logic [sys_pkg::DIM_W-1:0] o_vmin,
	input wire logic [sys_pkg::DIM_W-1:0] o_vmax
);

	// Number of failed assertions
	int unsigned fail_count = 0;

	////////////////////////////////////////
	// Host port echo
	////////////////////////////////////////

	// Acknowledge is the I/O clock two cycles late
	ack_echo: assert property (@(posedge clk_sys) disable iff (resetd)
		o_io_ack == $past(i_io_clk, 2))
		else begin
			fail_count++;
			$error("acknowledge does not match the I/O clock from two cycles before");
		end

	////////////////////////////////////////
	// Window ordering
	////////////////////////////////////////

	h_order: assert property (@(posedge clk_sys) disable iff (resetd)
		o_hmin <= o_hmax)
		else begin
			fail_count++;
			$error("horizontal window start is past its end");
		end

	v_order: assert property (@(posedge clk_sys) disable iff (resetd)
		o_vmin <= o_vmax)
		else begin
			fail_count++;
			$error("vertical window start is past its end");
		end

endmodule

bind video_scaler_ctrl_top scaler_ctrl_asserts scaler_ctrl_asserts_i (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_io_clk (i_io_clk),
	.o_io_ack (o_io_ack),
	.o_hmin   (o_hmin),
	.o_hmax   (o_hmax),
	.o_vmin   (o_vmin),
	.o_vmax   (o_vmax)
);

`default_nettype wire

//--- video_cfg_regs.sv
`default_nettype none
`timescale 1ns/10ps

module video_cfg_regs #(
	parameter logic [sys_pkg::DIM_W-1:0] DEFAULT_WIDTH  = sys_pkg::DEFAULT_WIDTH,
	parameter logic [sys_pkg::DIM_W-1:0] DEFAULT_HEIGHT = sys_pkg::DEFAULT_HEIGHT
) (
	input  wire logic                     clk_sys,
	input  wire logic                     resetd,
	input  wire logic                     i_wr,
	input  wire sys_pkg::cfg_field_e      i_field,
	input  wire logic [sys_pkg::IO_W-1:0] i_data,
	scaler_cfg_if.cfg_src                 o_cfg
);
	import sys_pkg::*;

	logic [DIM_W-1:0] wr_dim;

	// Dimensions live in the low bits of the host word
	assign wr_dim = i_data[DIM_W-1:0];

	////////////////////////////////////////
	// Field writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg.width     <= DEFAULT_WIDTH;
			o_cfg.height    <= DEFAULT_HEIGHT;
			o_cfg.vset      <= '0;
			o_cfg.hset      <= '0;
			o_cfg.freescale <= 1'b0;
			o_cfg.arc1x     <= '0;
			o_cfg.arc1y     <= '0;
			o_cfg.arc2x     <= '0;
			o_cfg.arc2y     <= '0;
		end else if (i_wr) begin
			case (i_field)
				FLD_WIDTH: begin
					o_cfg.width <= wr_dim;
				end
				FLD_HEIGHT: begin
					o_cfg.height <= wr_dim;
				end
				FLD_VSET: begin
					o_cfg.vset <= wr_dim;
				end
				FLD_HSET: begin
					// Top bit of the word is the free-scale flag
					o_cfg.hset      <= wr_dim;
					o_cfg.freescale <= i_data[IO_W-1];
				end
				FLD_ARC1X: begin
					o_cfg.arc1x <= wr_dim;
				end
				FLD_ARC1Y: begin
					o_cfg.arc1y <= wr_dim;
				end
				FLD_ARC2X: begin
					o_cfg.arc2x <= wr_dim;
				end
				FLD_ARC2Y: begin
					o_cfg.arc2y <= wr_dim;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- video_scaler_ctrl_top.sv
`default_nettype none
`timescale 1ns/10ps

module video_scaler_ctrl_top #(
	parameter logic [sys_pkg::DIM_W-1:0] DEFAULT_WIDTH  = sys_pkg::DEFAULT_WIDTH,
	parameter logic [sys_pkg::DIM_W-1:0] DEFAULT_HEIGHT = sys_pkg::DEFAULT_HEIGHT
) (
	input  wire logic                      clk_sys,
	input  wire logic                      resetd,
	input  wire logic                      i_io_clk,
	input  wire logic                      i_io_uio,
	input  wire logic [sys_pkg::IO_W-1:0]  i_io_din,
	input  wire logic [sys_pkg::DIM_W-1:0] i_arx,
	input  wire logic [sys_pkg::DIM_W-1:0] i_ary,
	output logic                           o_io_ack,
	output logic [sys_pkg::DIM_W-1:0]      o_hmin,
	output logic [sys_pkg::DIM_W-1:0]      o_hmax,
	output logic [sys_pkg::DIM_W-1:0]      o_vmin,
	output logic [sys_pkg::DIM_W-1:0]      o_vmax
);
	import sys_pkg::*;

	// Decoder to register bank
	logic            cfg_wr;
	cfg_field_e      cfg_field;
	logic [IO_W-1:0] cfg_data;

	scaler_cfg_if scaler_cfg ();

	////////////////////////////////////////
	// Host command path
	////////////////////////////////////////

	host_cmd_decoder host_cmd_decoder_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (i_io_clk),
		.i_io_uio (i_io_uio),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.o_wr     (cfg_wr),
		.o_field  (cfg_field),
		.o_data   (cfg_data)
	);

	video_cfg_regs #(
		.DEFAULT_WIDTH  (DEFAULT_WIDTH),
		.DEFAULT_HEIGHT (DEFAULT_HEIGHT)
	) video_cfg_regs_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_wr    (cfg_wr),
		.i_field (cfg_field),
		.i_data  (cfg_data),
		.o_cfg   (scaler_cfg)
	);

	////////////////////////////////////////
	// Output window
	////////////////////////////////////////

	aspect_window_calc aspect_window_calc_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_cfg   (scaler_cfg),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

endmodule

`default_nettype wire
